//--- Makefile
VERILATOR   = verilator
TOP         = branch_predictor_tb
FILE_LIST   = branch_predictor.f
LINT_FLAGS  = --lint-only --timing
BUILD_FLAGS = --binary --timing
OBJ_DIR     = obj_dir
LOG         = sim.log
PASS_TEXT   = Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

sim:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILE_LIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "run passed"; \
	else \
		echo "run failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- branch_predictor.f
+incdir+sim
hw/bp_pkg.sv
hw/branch_resolve_stage.sv
hw/branch_prediction_unit.sv
hw/bp_stats_apb.sv
hw/branch_predictor_top.sv
sim/branch_predictor_tb.sv

//--- hw/bp_pkg.sv
package bp_pkg;

    localparam int xlen          = 32; // address and data width.
    localparam int apb_addr_bits = 8;

    // defaults for the top level parameters.
    localparam int default_counter_index_bits = 6;
    localparam int default_btb_index_bits     = 4;
    localparam int default_counter_bits       = 2;

    typedef logic [xlen-1:0] addr_t;

    // resolved control instruction from execute, with the guess fetch made for it.
    typedef struct packed {
        logic  valid;
        addr_t pc;
        logic  taken;
        addr_t target_pc;
        logic  predicted_taken;
        addr_t predicted_target_pc;
    } resolve_t;

    typedef struct packed {
        logic  valid;
        addr_t pc;
        logic  taken;
        addr_t target_pc;
    } update_t;

    typedef struct packed {
        logic  valid;
        addr_t next_pc; // pc fetch restarts from.
    } redirect_t;

    typedef struct packed {
        logic  taken;
        addr_t target_pc;
    } prediction_t;

    typedef struct packed {
        logic                     psel;
        logic                     penable;
        logic                     pwrite;
        logic [apb_addr_bits-1:0] paddr;
        addr_t                    pwdata;
    } apb_req_t;

endpackage

//--- hw/bp_stats_apb.sv
`timescale 1ns/10ps

module bp_stats_apb (
    input  logic             clock,
    input  logic             reset,
    input  bp_pkg::apb_req_t apb,
    output bp_pkg::addr_t    prdata,
    input  bp_pkg::update_t  update,
    input  logic             mispredict,
    output logic             predict_enable
);

    localparam logic [bp_pkg::apb_addr_bits-1:0] ctrl_addr       = 'h00;
    localparam logic [bp_pkg::apb_addr_bits-1:0] branch_addr     = 'h04;
    localparam logic [bp_pkg::apb_addr_bits-1:0] taken_addr      = 'h08;
    localparam logic [bp_pkg::apb_addr_bits-1:0] mispredict_addr = 'h0C;
    localparam logic [bp_pkg::apb_addr_bits-1:0] clear_addr      = 'h10;

    localparam int stat_count_n = 3;
    localparam int branch_slot     = 0;
    localparam int taken_slot      = 1;
    localparam int mispredict_slot = 2;

    logic                                    access;
    logic                                    write_access;
    logic                                    read_access;
    logic                                    clear_write;
    logic [stat_count_n-1:0]                 count_event;
    logic [stat_count_n-1:0][bp_pkg::xlen-1:0] stat_count;

    // second cycle of the transfer; no wait states.
    assign access       = apb.psel && apb.penable;
    assign write_access = access && apb.pwrite;
    assign read_access  = access && !apb.pwrite;
    assign clear_write  = write_access && (apb.paddr == clear_addr);

    always_ff @(posedge clock) begin
        if (reset) begin
            predict_enable <= 1'b1;
        end else if (write_access && (apb.paddr == ctrl_addr)) begin
            predict_enable <= apb.pwdata[0];
        end
    end

    assign count_event[branch_slot]     = update.valid;
    assign count_event[taken_slot]      = update.valid && update.taken;
    assign count_event[mispredict_slot] = mispredict;

    // a clear in the same cycle as an event drops the event.
    always_ff @(posedge clock) begin
        if (reset || clear_write) begin
            stat_count <= '0;
        end else begin
            for (int i = 0; i < stat_count_n; i++) begin
                if (count_event[i]) begin
                    stat_count[i] <= stat_count[i] + 1'b1;
                end
            end
        end
    end

    always_comb begin
        prdata = '0; // unmapped and write-only addresses read as zero.
        if (read_access) begin
            case (apb.paddr)
                ctrl_addr:       prdata[0] = predict_enable;
                branch_addr:     prdata    = stat_count[branch_slot];
                taken_addr:      prdata    = stat_count[taken_slot];
                mispredict_addr: prdata    = stat_count[mispredict_slot];
                default:         prdata    = '0;
            endcase
        end
    end

endmodule

//--- hw/branch_prediction_unit.sv
`timescale 1ns/10ps

module branch_prediction_unit #(
    parameter int counter_index_bits = bp_pkg::default_counter_index_bits,
    parameter int btb_index_bits     = bp_pkg::default_btb_index_bits,
    parameter int counter_bits       = bp_pkg::default_counter_bits
) (
    input  logic                clock,
    input  logic                reset,
    input  logic                predict_enable,
    input  bp_pkg::addr_t       fetch_pc,
    input  bp_pkg::update_t     update,
    output bp_pkg::prediction_t prediction
);

    localparam int counter_entries = 1 << counter_index_bits;
    localparam int btb_entries     = 1 << btb_index_bits;
    // pc bits 1:0 are always zero, so indexing starts at bit 2.
    localparam int tag_bits        = bp_pkg::xlen - btb_index_bits - 2;

    typedef struct packed {
        logic                valid;
        logic [tag_bits-1:0] tag;
        bp_pkg::addr_t       target_pc;
    } btb_entry_t;

    logic [counter_bits-1:0]       counters [counter_entries];
    btb_entry_t                    btb [btb_entries];

    logic [counter_index_bits-1:0] fetch_counter_index;
    logic [btb_index_bits-1:0]     fetch_btb_index;
    logic [tag_bits-1:0]           fetch_tag;
    btb_entry_t                    fetch_entry;
    logic                          btb_hit;

    logic [counter_index_bits-1:0] update_counter_index;
    logic [btb_index_bits-1:0]     update_btb_index;
    logic [counter_bits-1:0]       count_now;
    logic [counter_bits-1:0]       count_next;
    btb_entry_t                    new_entry;

    assign fetch_counter_index = fetch_pc[counter_index_bits+1:2];
    assign fetch_btb_index     = fetch_pc[btb_index_bits+1:2];
    assign fetch_tag           = fetch_pc[bp_pkg::xlen-1 -: tag_bits];

    assign fetch_entry = btb[fetch_btb_index];
    assign btb_hit     = fetch_entry.valid && (fetch_entry.tag == fetch_tag);

    // counter msb gives the direction; without a BTB hit there is no target to use.
    assign prediction.taken = predict_enable && counters[fetch_counter_index][counter_bits-1] &&
                              btb_hit;
    assign prediction.target_pc = fetch_entry.target_pc;

    assign update_counter_index = update.pc[counter_index_bits+1:2];
    assign update_btb_index     = update.pc[btb_index_bits+1:2];
    assign count_now            = counters[update_counter_index];

    // saturating counter step.
    always_comb begin
        count_next = count_now;
        if (update.taken) begin
            if (count_now != '1) begin
                count_next = count_now + 1'b1;
            end
        end else if (count_now != '0) begin
            count_next = count_now - 1'b1;
        end
    end

    assign new_entry.valid     = 1'b1;
    assign new_entry.tag       = update.pc[bp_pkg::xlen-1 -: tag_bits];
    assign new_entry.target_pc = update.target_pc;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < counter_entries; i++) begin
                counters[i] <= '1; // start out leaning taken.
            end
            for (int i = 0; i < btb_entries; i++) begin
                btb[i].valid <= 1'b0;
            end
        end else if (update.valid) begin
            counters[update_counter_index] <= count_next;
            if (update.taken) begin
                btb[update_btb_index] <= new_entry; // replaces any other tag at this index.
            end
        end
    end

endmodule

//--- hw/branch_predictor_top.sv
`timescale 1ns/10ps

module branch_predictor_top #(
    parameter int counter_index_bits = bp_pkg::default_counter_index_bits,
    parameter int btb_index_bits     = bp_pkg::default_btb_index_bits,
    parameter int counter_bits       = bp_pkg::default_counter_bits
) (
    input  logic                clock,
    input  logic                reset,
    input  bp_pkg::addr_t       fetch_pc,
    output bp_pkg::prediction_t prediction,
    input  bp_pkg::resolve_t    resolve,
    output bp_pkg::redirect_t   redirect,
    input  bp_pkg::apb_req_t    apb,
    output bp_pkg::addr_t       prdata
);

    bp_pkg::update_t update;         // registered report, trains tables and counts.
    logic            mispredict;
    logic            predict_enable;

    branch_resolve_stage resolve_stage (
        .clock      (clock),
        .reset      (reset),
        .resolve    (resolve),
        .update     (update),
        .redirect   (redirect),
        .mispredict (mispredict)
    );

    branch_prediction_unit #(
        .counter_index_bits (counter_index_bits),
        .btb_index_bits     (btb_index_bits),
        .counter_bits       (counter_bits)
    ) prediction_unit (
        .clock          (clock),
        .reset          (reset),
        .predict_enable (predict_enable),
        .fetch_pc       (fetch_pc),
        .update         (update),
        .prediction     (prediction)
    );

    // register block on the APB side.
    bp_stats_apb stats (
        .clock          (clock),
        .reset          (reset),
        .apb            (apb),
        .prdata         (prdata),
        .update         (update),
        .mispredict     (mispredict),
        .predict_enable (predict_enable)
    );

endmodule

//--- hw/branch_resolve_stage.sv
`timescale 1ns/10ps

module branch_resolve_stage (
    input  logic              clock,
    input  logic              reset,
    input  bp_pkg::resolve_t  resolve,
    output bp_pkg::update_t   update,
    output bp_pkg::redirect_t redirect,
    output logic              mispredict
);

    bp_pkg::resolve_t report;          // report as sampled at the last edge.
    logic             direction_wrong;
    logic             target_wrong;
    bp_pkg::addr_t    fall_through_pc;
    bp_pkg::addr_t    correct_pc;

    // one report per cycle, no stall.
    always_ff @(posedge clock) begin
        if (reset) begin
            report.valid <= 1'b0;
        end else begin
            report <= resolve;
        end
    end

    // guessed the wrong way.
    assign direction_wrong = report.taken != report.predicted_taken;

    // right direction but the BTB gave a stale target.
    assign target_wrong = report.taken && report.predicted_taken &&
                          (report.target_pc != report.predicted_target_pc);

    assign mispredict = report.valid && (direction_wrong || target_wrong);

    // instructions are fixed length.
    assign fall_through_pc = report.pc + bp_pkg::xlen'(4);

    assign correct_pc = report.taken ? report.target_pc : fall_through_pc;

    assign redirect.valid   = mispredict;  // high for the one cycle the report is held.
    assign redirect.next_pc = correct_pc;

    // every resolved branch trains the tables, right or wrong.
    assign update.valid     = report.valid;
    assign update.pc        = report.pc;
    assign update.taken     = report.taken;
    assign update.target_pc = report.target_pc;

endmodule

//--- sim/bp_patterns.txt
# columns: op test_name, then hex fields. res: pc taken target pred_taken pred_target;
# rdr: valid next_pc; look: pc taken target; wr: addr data; rd: addr expected_data.
look b1_reset_a               00001010 0 00000000
look b1_reset_b               00002020 0 00000000
res  b2_train_a               00001010 1 00002000 0 00000000
rdr  b2_redirect_a            1 00002000
look b2_hit_a                 00001010 1 00002000
res  b5_correct_a             00001010 1 00002000 1 00002000
rdr  b5_no_redirect           0 00000000
res  b5_target_a              00001010 1 00002400 1 00002000
rdr  b5_redirect_target       1 00002400
look b5_new_target            00001010 1 00002400
res  b3_not_taken1            00001010 0 00002400 1 00002400
rdr  b3_redirect_nt1          1 00001014
look b3_still_taken           00001010 1 00002400
res  b3_not_taken2            00001010 0 00002400 1 00002400
rdr  b3_redirect_nt2          1 00001014
look b3_now_not_taken         00001010 0 00000000
res  b3_not_taken3            00001010 0 00002400 0 00002400
rdr  b3_no_redirect_nt3       0 00000000
res  b3_taken_again1          00001010 1 00002400 0 00002400
rdr  b3_redirect_taken1       1 00002400
look b3_still_not_taken       00001010 0 00000000
res  b3_taken_again2          00001010 1 00002400 0 00002400
rdr  b3_redirect_taken2       1 00002400
look b3_taken_restored        00001010 1 00002400
look b4_alias_c               00003090 0 00000000
res  b4_train_c               00003090 1 00005000 0 00000000
rdr  b4_redirect_c            1 00005000
look b4_hit_c                 00003090 1 00005000
look b4_evicted_a             00001010 0 00000000
wr   b6_disable               00 00000000
rd   b6_ctrl_off              00 00000000
look b6_off_c                 00003090 0 00000000
res  b6_train_d               00004030 1 00006000 0 00000000
rdr  b6_redirect_d            1 00006000
look b6_off_d                 00004030 0 00000000
wr   b6_enable                00 00000001
rd   b6_ctrl_on               00 00000001
look b6_on_d                  00004030 1 00006000
look b6_on_c                  00003090 1 00005000
res  b5_back1                 00002020 0 00000000 0 00000000
rdr  b5_back1_no_redirect     0 00000000
res  b5_back2                 00004030 1 00006000 1 00006000
rdr  b5_back2_no_redirect     0 00000000
rd   b5_branch_count          04 0000000c
rd   b5_taken_count           08 00000008
rd   b5_mispredict_count      0c 00000008
rd   b5_unmapped              14 00000000
wr   b5_clear                 10 00000000
rd   b5_branch_cleared        04 00000000
rd   b5_taken_cleared         08 00000000
rd   b5_mispredict_cleared    0c 00000000

//--- sim/bp_tb_checks.svh
`ifndef bp_tb_checks_svh
`define bp_tb_checks_svh

int prediction_errors = 0;
int redirect_errors   = 0;
int register_errors   = 0;
int pattern_errors    = 0; // malformed or unknown lines in the pattern file.

// the target only matters when the lookup is expected to be taken.
task automatic check_prediction(input string               test_name,
                                input bp_pkg::prediction_t expected,
                                input bp_pkg::prediction_t actual);
    if ((actual.taken !== expected.taken) ||
        (expected.taken && (actual.target_pc !== expected.target_pc))) begin
        prediction_errors++;
        $display("ERROR %s: prediction expected taken=%0b target=%h, actual taken=%0b target=%h",
                 test_name, expected.taken, expected.target_pc, actual.taken, actual.target_pc);
    end
endtask

// next_pc is compared only when a redirect is expected.
task automatic check_redirect(input string             test_name,
                              input bp_pkg::redirect_t expected,
                              input bp_pkg::redirect_t actual);
    if ((actual.valid !== expected.valid) ||
        (expected.valid && (actual.next_pc !== expected.next_pc))) begin
        redirect_errors++;
        $display("ERROR %s: redirect expected valid=%0b next_pc=%h, actual valid=%0b next_pc=%h",
                 test_name, expected.valid, expected.next_pc, actual.valid, actual.next_pc);
    end
endtask

task automatic check_register(input string         test_name,
                              input bp_pkg::addr_t expected,
                              input bp_pkg::addr_t actual);
    if (actual !== expected) begin
        register_errors++;
        $display("ERROR %s: register expected %h, actual %h", test_name, expected, actual);
    end
endtask

function automatic int total_errors();
    return prediction_errors + redirect_errors + register_errors + pattern_errors;
endfunction

`endif

//--- sim/branch_predictor_tb.sv
`timescale 1ns/10ps

module branch_predictor_tb;

    localparam int    clock_period = 20;
    localparam int    reset_cycles = 5;
    localparam string pattern_path = "sim/bp_patterns.txt";

    logic                clock;
    logic                reset;
    bp_pkg::addr_t       fetch_pc;
    bp_pkg::prediction_t prediction;
    bp_pkg::resolve_t    resolve;
    bp_pkg::redirect_t   redirect;
    bp_pkg::apb_req_t    apb;
    bp_pkg::addr_t       prdata;

    int pattern_lines = 0;
    bit lines_known   = 1'b0; // set once the pattern file has been counted.

    `include "bp_tb_checks.svh"

    branch_predictor_top uut (
        .clock      (clock),
        .reset      (reset),
        .fetch_pc   (fetch_pc),
        .prediction (prediction),
        .resolve    (resolve),
        .redirect   (redirect),
        .apb        (apb),
        .prdata     (prdata)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #(clock_period / 2) clock = ~clock;
        end
    end

    // report is held for one cycle and the redirect is visible on return.
    task automatic drive_resolve(input bp_pkg::resolve_t report);
        resolve = report;
        @(negedge clock);
        resolve.valid = 1'b0;
    endtask

    // prediction sampled mid-cycle, after the edge that may have trained the tables.
    task automatic lookup(input string test_name, input bp_pkg::addr_t pc,
                          input bp_pkg::prediction_t expected);
        fetch_pc = pc;
        @(negedge clock);
        check_prediction(test_name, expected, prediction);
    endtask

    task automatic apb_write(input logic [bp_pkg::apb_addr_bits-1:0] addr,
                             input bp_pkg::addr_t data);
        apb.psel    = 1'b1;
        apb.penable = 1'b0;
        apb.pwrite  = 1'b1;
        apb.paddr   = addr;
        apb.pwdata  = data;
        @(negedge clock);
        apb.penable = 1'b1;
        @(negedge clock);
        apb.psel    = 1'b0;
        apb.penable = 1'b0;
    endtask

    task automatic apb_read(input logic [bp_pkg::apb_addr_bits-1:0] addr,
                            output bp_pkg::addr_t data);
        apb.psel    = 1'b1;
        apb.penable = 1'b0;
        apb.pwrite  = 1'b0;
        apb.paddr   = addr;
        @(negedge clock);
        apb.penable = 1'b1;
        @(posedge clock);
        data = prdata; // value seen by the edge ending the access cycle.
        @(negedge clock);
        apb.psel    = 1'b0;
        apb.penable = 1'b0;
    endtask

    task automatic report_malformed_line(input string op, input string test_name);
        pattern_errors++;
        $display("pattern line %s %s does not have the fields its operation needs", op, test_name);
    endtask

    task automatic run_patterns(input int fd);
        string               op;
        string               test_name;
        string               line;
        int                  fields;
        bp_pkg::addr_t       v0;
        bp_pkg::addr_t       v1;
        bp_pkg::addr_t       v2;
        bp_pkg::addr_t       v3;
        bp_pkg::addr_t       v4;
        bp_pkg::resolve_t    report;
        bp_pkg::prediction_t expected_prediction;
        bp_pkg::redirect_t   expected_redirect;
        bp_pkg::addr_t       read_data;

        while ($fscanf(fd, "%s", op) == 1) begin
            if (op == "#") begin
                fields = $fgets(line, fd); // skip the rest of a comment line.
            end else begin
                fields = $fscanf(fd, "%s", test_name);
                case (op)
                    "res": begin
                        fields = $fscanf(fd, "%h %h %h %h %h", v0, v1, v2, v3, v4);
                        if (fields != 5) begin
                            report_malformed_line(op, test_name);
                        end else begin
                            report                     = '0;
                            report.valid               = 1'b1;
                            report.pc                  = v0;
                            report.taken               = v1[0];
                            report.target_pc           = v2;
                            report.predicted_taken     = v3[0];
                            report.predicted_target_pc = v4;
                            drive_resolve(report);
                        end
                    end
                    "rdr": begin
                        fields = $fscanf(fd, "%h %h", v0, v1);
                        if (fields != 2) begin
                            report_malformed_line(op, test_name);
                        end else begin
                            expected_redirect.valid   = v0[0];
                            expected_redirect.next_pc = v1;
                            check_redirect(test_name, expected_redirect, redirect);
                        end
                    end
                    "look": begin
                        fields = $fscanf(fd, "%h %h %h", v0, v1, v2);
                        if (fields != 3) begin
                            report_malformed_line(op, test_name);
                        end else begin
                            expected_prediction.taken     = v1[0];
                            expected_prediction.target_pc = v2;
                            lookup(test_name, v0, expected_prediction);
                        end
                    end
                    "wr": begin
                        fields = $fscanf(fd, "%h %h", v0, v1);
                        if (fields != 2) begin
                            report_malformed_line(op, test_name);
                        end else begin
                            apb_write(v0[bp_pkg::apb_addr_bits-1:0], v1);
                        end
                    end
                    "rd": begin
                        fields = $fscanf(fd, "%h %h", v0, v1);
                        if (fields != 2) begin
                            report_malformed_line(op, test_name);
                        end else begin
                            apb_read(v0[bp_pkg::apb_addr_bits-1:0], read_data);
                            check_register(test_name, v1, read_data);
                        end
                    end
                    default: begin
                        pattern_errors++;
                        $display("unknown operation %s in the pattern file", op);
                    end
                endcase
            end
        end
    endtask

    initial begin
        int    fd;
        int    line_count;
        string line;

        reset    = 1'b1;
        fetch_pc = '0;
        resolve  = '0;
        apb      = '0;

        fd = $fopen(pattern_path, "r");
        if (fd == 0) begin
            $display("could not open the pattern file %s", pattern_path);
            $display("Simulation failed");
            $finish;
        end else begin
            line_count = 0;
            while ($fgets(line, fd) != 0) begin
                line_count++;
            end
            $fclose(fd);
            pattern_lines = line_count;
            lines_known   = 1'b1;
            fd = $fopen(pattern_path, "r");

            repeat (reset_cycles) @(posedge clock);
            @(negedge clock);
            reset = 1'b0;

            run_patterns(fd);
            $fclose(fd);

            $display("errors: %0d (prediction %0d, redirect %0d, register %0d, pattern %0d)",
                     total_errors(), prediction_errors, redirect_errors, register_errors,
                     pattern_errors);
            if (total_errors() == 0) begin
                $display("Simulation completed successfully");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

    // no pattern line needs more than a few cycles.
    initial begin
        wait (lines_known);
        repeat (pattern_lines * 10 + reset_cycles) @(posedge clock);
        $display("timeout: the pattern file did not finish within %0d cycles",
                 pattern_lines * 10 + reset_cycles);
        $display("Simulation failed");
        $finish;
    end

endmodule
